//--- hdl/ql_video_pkg.sv
package ql_video_pkg;

	// ql colour, red green blue from the top bit down
	typedef logic [2:0] color_t;

	localparam color_t BLACK   = 3'b000;
	localparam color_t BLUE    = 3'b001;
	localparam color_t GREEN   = 3'b010;
	localparam color_t CYAN    = 3'b011;
	localparam color_t RED     = 3'b100;
	localparam color_t MAGENTA = 3'b101;
	localparam color_t YELLOW  = 3'b110;
	localparam color_t WHITE   = 3'b111;

	// MC_STAT bit positions
	localparam int MC_MEMBASE = 7; // screen base select
	localparam int MC_MODE    = 3; // 0 = 512 wide 2bpp, 1 = 256 wide 4bpp
	localparam int MC_BLANK   = 1; // picture off

	localparam int ADDR_W = 19; // word address into screen memory

	localparam logic [ADDR_W-1:0] BASE_LOW  = 19'h10000;
	localparam logic [ADDR_W-1:0] BASE_HIGH = 19'h14000;

	localparam logic [1:0] AXI_OKAY   = 2'b00;
	localparam logic [1:0] AXI_SLVERR = 2'b10;

	localparam logic [3:0] REG_MC_STAT = 4'h0; // byte address of MC_STAT

endpackage

//--- hdl/mc_stat_regs.sv
module mc_stat_regs (
	input  logic        clk_video,
	input  logic        reset,
	input  logic [3:0]  s_axi_awaddr,
	input  logic        s_axi_awvalid,
	output logic        s_axi_awready,
	input  logic [31:0] s_axi_wdata,
	input  logic        s_axi_wvalid,
	output logic        s_axi_wready,
	output logic [1:0]  s_axi_bresp,
	output logic        s_axi_bvalid,
	input  logic        s_axi_bready,
	input  logic [3:0]  s_axi_araddr,
	input  logic        s_axi_arvalid,
	output logic        s_axi_arready,
	output logic [31:0] s_axi_rdata,
	output logic [1:0]  s_axi_rresp,
	output logic        s_axi_rvalid,
	input  logic        s_axi_rready,
	input  logic        frame_start,
	output logic        membase,
	output logic        mode,
	output logic        blank
);
	import ql_video_pkg::*;

	logic [7:0] mc_stat;
	logic       aw_take; // address and data taken together
	logic       ar_take;

	// no new request while its response is still waiting
	assign aw_take = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
	assign ar_take = s_axi_arvalid && !s_axi_rvalid;

	assign s_axi_awready = aw_take;
	assign s_axi_wready  = aw_take;
	assign s_axi_arready = ar_take;

	always_ff @(posedge clk_video) begin
		if (reset) begin
			mc_stat      <= 8'h00;
			s_axi_bvalid <= 1'b0;
		end else if (aw_take) begin
			s_axi_bvalid <= 1'b1;
			if (s_axi_awaddr == REG_MC_STAT)
				mc_stat <= s_axi_wdata[7:0]; // only the low byte exists
		end else if (s_axi_bready) begin
			s_axi_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_video) begin
		if (aw_take)
			s_axi_bresp <= (s_axi_awaddr == REG_MC_STAT) ? AXI_OKAY : AXI_SLVERR;
	end

	always_ff @(posedge clk_video) begin
		if (reset)
			s_axi_rvalid <= 1'b0;
		else if (ar_take)
			s_axi_rvalid <= 1'b1;
		else if (s_axi_rready)
			s_axi_rvalid <= 1'b0;
	end

	always_ff @(posedge clk_video) begin
		if (ar_take) begin
			if (s_axi_araddr == REG_MC_STAT) begin
				s_axi_rdata <= {24'h000000, mc_stat};
				s_axi_rresp <= AXI_OKAY;
			end else begin
				s_axi_rdata <= 32'h0; // bad address reads as zero
				s_axi_rresp <= AXI_SLVERR;
			end
		end
	end

	// display side only sees a new value from the next frame on
	always_ff @(posedge clk_video) begin
		if (reset) begin
			membase <= 1'b0;
			mode    <= 1'b0;
			blank   <= 1'b0;
		end else if (frame_start) begin
			membase <= mc_stat[MC_MEMBASE];
			mode    <= mc_stat[MC_MODE];
			blank   <= mc_stat[MC_BLANK];
		end
	end

	assert property (@(posedge clk_video) disable iff (reset)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);
	assert property (@(posedge clk_video) disable iff (reset)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

endmodule

//--- hdl/video_timing.sv
module video_timing #(
	parameter int H_VISIBLE,
	parameter int H_FP,
	parameter int H_SYNC,
	parameter int H_BP,
	parameter int V_VISIBLE,
	parameter int V_FP,
	parameter int V_SYNC,
	parameter int V_BP,
	parameter int FLASH_FRAMES,
	localparam int H_TOTAL = H_VISIBLE + H_FP + H_SYNC + H_BP,
	localparam int V_TOTAL = V_VISIBLE + V_FP + V_SYNC + V_BP,
	localparam int HW = $clog2(H_TOTAL),
	localparam int VW = $clog2(V_TOTAL)
) (
	input  logic          clk_video,
	input  logic          reset,
	output logic [HW-1:0] h_cnt,
	output logic [VW-1:0] v_cnt,
	output logic          display,
	output logic          line_start,
	output logic          frame_start,
	output logic          fetch_req,
	output logic          flash_state,
	output logic          hs,
	output logic          vs
);
	localparam int FW = $clog2(FLASH_FRAMES + 2);

	localparam logic [HW-1:0] H_LAST    = HW'(H_TOTAL - 1);
	localparam logic [HW-1:0] H_PRE     = HW'(H_TOTAL - 2); // word 0 of the next line
	localparam logic [HW-1:0] H_VIS     = HW'(H_VISIBLE);
	localparam logic [HW-1:0] H_FETCH   = HW'(H_VISIBLE - 8); // last in-line request below
	localparam logic [HW-1:0] HS_START  = HW'(H_VISIBLE + H_FP);
	localparam logic [HW-1:0] HS_END    = HW'(H_VISIBLE + H_FP + H_SYNC);
	localparam logic [VW-1:0] V_LAST    = VW'(V_TOTAL - 1);
	localparam logic [VW-1:0] V_VIS     = VW'(V_VISIBLE);
	localparam logic [VW-1:0] V_PRE     = VW'(V_VISIBLE - 1);
	localparam logic [VW-1:0] VS_START  = VW'(V_VISIBLE + V_FP);
	localparam logic [VW-1:0] VS_END    = VW'(V_VISIBLE + V_FP + V_SYNC);
	localparam logic [FW-1:0] FLASH_END = FW'(FLASH_FRAMES);

	logic          hs_q; // sync stage 1
	logic          vs_q;
	logic          next_vis; // line after this one is displayed
	logic [FW-1:0] flash_cnt;

	always_ff @(posedge clk_video) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1; // vertical steps at line wrap
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign display     = (h_cnt < H_VIS) && (v_cnt < V_VIS);
	assign line_start  = (h_cnt == '0);
	assign frame_start = line_start && (v_cnt == '0);

	// last frame line wraps to line 0, which is always visible
	assign next_vis = (v_cnt == V_LAST) || (v_cnt < V_PRE);

	// one request two clocks ahead of every 8 pixel group
	assign fetch_req = ((h_cnt == H_PRE) && next_vis) ||
		((h_cnt[2:0] == 3'd6) && (h_cnt < H_FETCH) && (v_cnt < V_VIS));

	// two register stages line up with the decoder pipeline
	always_ff @(posedge clk_video) begin
		if (reset) begin
			hs_q <= 1'b1;
			vs_q <= 1'b0;
			hs   <= 1'b1;
			vs   <= 1'b0;
		end else begin
			hs_q <= !((h_cnt >= HS_START) && (h_cnt < HS_END)); // negative hsync
			vs_q <= (v_cnt >= VS_START) && (v_cnt < VS_END);    // positive vsync
			hs   <= hs_q;
			vs   <= vs_q;
		end
	end

	// 4bpp flash timebase
	always_ff @(posedge clk_video) begin
		if (reset) begin
			flash_cnt   <= '0;
			flash_state <= 1'b0;
		end else if (frame_start) begin
			if (flash_cnt == FLASH_END) begin
				flash_cnt   <= '0;
				flash_state <= !flash_state;
			end else begin
				flash_cnt <= flash_cnt + 1'b1;
			end
		end
	end

	// vs moves two clocks after the line wrap, clear of the hs edges
	// unless the back porch is empty and the sync end lands there too
	assert property (@(posedge clk_video) disable iff (reset)
		(vs != $past(vs)) |-> (h_cnt == HW'(2)) && ((hs == $past(hs)) || (H_BP == 0)));

endmodule

//--- hdl/screen_fetch.sv
module screen_fetch (
	input  logic                            clk_video,
	input  logic                            reset,
	input  logic                            frame_start,
	input  logic                            fetch_req,
	input  logic                            membase,
	output logic                            rd,
	output logic [ql_video_pkg::ADDR_W-1:0] addr,
	input  logic [15:0]                     din,
	output logic [15:0]                     word
);
	import ql_video_pkg::*;

	logic rd_d;   // din valid this cycle
	logic reload; // shadow copy of membase is fresh

	assign rd = fetch_req; // memory samples addr with rd

	// word 0 of line 0 goes out just ahead of frame_start,
	// so it is the last address of the run before the reload
	always_ff @(posedge clk_video) begin
		if (reset) begin
			reload <= 1'b0;
			addr   <= '0;
		end else begin
			reload <= frame_start; // base swaps one clock after the shadow copy
			if (reload)
				addr <= membase ? BASE_HIGH : BASE_LOW;
			else if (fetch_req)
				addr <= addr + 1'b1;
		end
	end

	// fixed one clock memory latency
	always_ff @(posedge clk_video) begin
		if (reset) begin
			rd_d <= 1'b0;
			word <= 16'h0000; // first group after reset shows black
		end else begin
			rd_d <= fetch_req;
			if (rd_d)
				word <= din;
		end
	end

	assert property (@(posedge clk_video) disable iff (reset) rd |=> !rd);

endmodule

//--- hdl/pixel_decoder.sv
module pixel_decoder (
	input  logic        clk_video,
	input  logic        reset,
	input  logic [2:0]  h_cnt,
	input  logic        display,
	input  logic        line_start,
	input  logic [15:0] word,
	input  logic        mode,
	input  logic        blank,
	input  logic        flash_state,
	output logic        de,
	output logic [5:0]  r,
	output logic [5:0]  g,
	output logic [5:0]  b
);
	import ql_video_pkg::*;

	logic [15:0] shifter; // current pixel at bits 15 and 7
	logic        display_d;
	logic        odd_d;      // second clock of a 4bpp pixel
	logic        flash_flag; // flashing region active on this line
	logic        flash_hit;
	color_t      flash_col;  // colour held for the flashing region
	color_t      col_2bpp;
	color_t      col_own;
	color_t      col_4bpp;
	color_t      pixel;

	// stage 1, load on the group boundary and shift out pixels
	always_ff @(posedge clk_video) begin
		if (h_cnt == 3'd0)
			shifter <= word;
		else if (!mode)
			shifter <= {shifter[14:8], 1'b0, shifter[6:0], 1'b0}; // g and r bytes
		else if (!h_cnt[0])
			shifter <= {shifter[13:8], 2'b00, shifter[5:0], 2'b00}; // gf and rb pairs
	end

	always_ff @(posedge clk_video) begin
		if (reset) begin
			display_d <= 1'b0;
			odd_d     <= 1'b0;
		end else begin
			display_d <= display;
			odd_d     <= h_cnt[0];
		end
	end

	// stage 2 decode
	always_comb begin
		case ({shifter[15], shifter[7]}) // green, red
			2'b00:   col_2bpp = BLACK;
			2'b01:   col_2bpp = RED;
			2'b10:   col_2bpp = GREEN;
			default: col_2bpp = WHITE;
		endcase
		case ({shifter[15], shifter[7], shifter[6]}) // green, red, blue
			3'd0:    col_own = BLACK;
			3'd1:    col_own = BLUE;
			3'd2:    col_own = RED;
			3'd3:    col_own = MAGENTA;
			3'd4:    col_own = GREEN;
			3'd5:    col_own = CYAN;
			3'd6:    col_own = YELLOW;
			default: col_own = WHITE;
		endcase
		// the pixel carrying the flash bit keeps its own colour
		if (flash_flag && flash_state && !shifter[14])
			col_4bpp = flash_col;
		else
			col_4bpp = col_own;
		if (!display_d || blank)
			pixel = BLACK; // blank keeps de running
		else if (mode)
			pixel = col_4bpp;
		else
			pixel = col_2bpp;
	end

	// toggle late in the pixel so it counts from the next one on
	assign flash_hit = mode && display_d && odd_d && shifter[14];

	always_ff @(posedge clk_video) begin
		if (reset)
			flash_flag <= 1'b0;
		else if (line_start)
			flash_flag <= 1'b0; // every line starts steady
		else if (flash_hit)
			flash_flag <= !flash_flag;
	end

	always_ff @(posedge clk_video) begin
		if (flash_hit)
			flash_col <= col_own;
	end

	always_ff @(posedge clk_video) begin
		if (reset) begin
			de <= 1'b0;
			r  <= 6'h00;
			g  <= 6'h00;
			b  <= 6'h00;
		end else begin
			de <= display_d;
			r  <= {6{pixel[2]}}; // full scale per colour bit
			g  <= {6{pixel[1]}};
			b  <= {6{pixel[0]}};
		end
	end

endmodule

//--- hdl/zx8301_video.sv
module zx8301_video #(
	parameter int H_VISIBLE    = 512, // pal porches by default
	parameter int H_FP         = 24,
	parameter int H_SYNC       = 72,
	parameter int H_BP         = 64,
	parameter int V_VISIBLE    = 256,
	parameter int V_FP         = 25,
	parameter int V_SYNC       = 6,
	parameter int V_BP         = 25,
	parameter int FLASH_FRAMES = 25
) (
	input  logic                            clk_video,
	input  logic                            reset,
	input  logic [3:0]                      s_axi_awaddr,
	input  logic                            s_axi_awvalid,
	output logic                            s_axi_awready,
	input  logic [31:0]                     s_axi_wdata,
	input  logic                            s_axi_wvalid,
	output logic                            s_axi_wready,
	output logic [1:0]                      s_axi_bresp,
	output logic                            s_axi_bvalid,
	input  logic                            s_axi_bready,
	input  logic [3:0]                      s_axi_araddr,
	input  logic                            s_axi_arvalid,
	output logic                            s_axi_arready,
	output logic [31:0]                     s_axi_rdata,
	output logic [1:0]                      s_axi_rresp,
	output logic                            s_axi_rvalid,
	input  logic                            s_axi_rready,
	output logic [ql_video_pkg::ADDR_W-1:0] addr,
	output logic                            rd,
	input  logic [15:0]                     din,
	output logic                            hs,
	output logic                            vs,
	output logic                            de,
	output logic [5:0]                      r,
	output logic [5:0]                      g,
	output logic [5:0]                      b
);
	localparam int HW = $clog2(H_VISIBLE + H_FP + H_SYNC + H_BP);

	logic [HW-1:0] h_cnt;
	logic [15:0]   word;
	logic          membase;
	logic          mode;
	logic          blank;
	logic          display;
	logic          line_start;
	logic          frame_start;
	logic          fetch_req;
	logic          flash_state;

	mc_stat_regs u_regs (
		.clk_video     (clk_video),
		.reset         (reset),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.frame_start   (frame_start),
		.membase       (membase),
		.mode          (mode),
		.blank         (blank)
	);

	video_timing #(
		.H_VISIBLE    (H_VISIBLE),
		.H_FP         (H_FP),
		.H_SYNC       (H_SYNC),
		.H_BP         (H_BP),
		.V_VISIBLE    (V_VISIBLE),
		.V_FP         (V_FP),
		.V_SYNC       (V_SYNC),
		.V_BP         (V_BP),
		.FLASH_FRAMES (FLASH_FRAMES)
	) u_timing (
		.clk_video   (clk_video),
		.reset       (reset),
		.h_cnt       (h_cnt),
		.v_cnt       (), // line position only matters inside the timing block
		.display     (display),
		.line_start  (line_start),
		.frame_start (frame_start),
		.fetch_req   (fetch_req),
		.flash_state (flash_state),
		.hs          (hs),
		.vs          (vs)
	);

	screen_fetch u_fetch (
		.clk_video   (clk_video),
		.reset       (reset),
		.frame_start (frame_start),
		.fetch_req   (fetch_req),
		.membase     (membase),
		.rd          (rd),
		.addr        (addr),
		.din         (din),
		.word        (word)
	);

	pixel_decoder u_decoder (
		.clk_video   (clk_video),
		.reset       (reset),
		.h_cnt       (h_cnt[2:0]), // pixel within the 8 pixel group
		.display     (display),
		.line_start  (line_start),
		.word        (word),
		.mode        (mode),
		.blank       (blank),
		.flash_state (flash_state),
		.de          (de),
		.r           (r),
		.g           (g),
		.b           (b)
	);

endmodule

//--- test/tb_zx8301_video.sv
module tb_zx8301_video;
	import ql_video_pkg::*;

	localparam int H_VIS = 32; // small frame of 48 x 8
	localparam int HT = 48;
	localparam int V_VIS = 4;
	localparam int VT = 8;
	localparam int FRAME = HT * VT;
	localparam int TEST_FRAMES = 20;
	localparam logic [20:0] RESET_OUT = {1'b1, 1'b0, 1'b0, 18'h0}; // hs vs de r g b

	logic        clk_video = 1'b0;
	logic        reset;
	logic [3:0]  awaddr, araddr;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic        awready, wready, bvalid, arready, rvalid;
	logic [31:0] wdata, rdata;
	logic [1:0]  bresp, rresp;
	logic [ADDR_W-1:0] addr;
	logic        rd, hs, vs, de;
	logic [15:0] din;
	logic [5:0]  r, g, b;

	logic [31:0] lcg_state = 32'hbb11_644e;
	logic [15:0] mem [256];
	logic [15:0] mem_word;
	logic        rd_last = 1'b0;
	logic        rst_edge = 1'b1; // reset seen at the last rising edge
	int          errors = 0;
	int          checks = 0;

	// model state
	logic [7:0]  m_stat = 8'h00; // MC_STAT as written over AXI
	logic [7:0]  shadow;
	int          mh, mv, fcnt;
	logic [ADDR_W-1:0] maddr;
	logic [15:0] mnext, mgrp;
	logic        fst, fflag;
	color_t      fcol;
	logic [20:0] e1, e2; // expected outputs one and two cycles back

	zx8301_video #(
		.H_VISIBLE(32), .H_FP(4), .H_SYNC(6), .H_BP(6),
		.V_VISIBLE(4), .V_FP(1), .V_SYNC(2), .V_BP(1),
		.FLASH_FRAMES(1)
	) UUT (
		.clk_video(clk_video), .reset(reset),
		.s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
		.s_axi_wdata(wdata), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
		.s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
		.s_axi_araddr(araddr), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
		.s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rvalid(rvalid),
		.s_axi_rready(rready),
		.addr(addr), .rd(rd), .din(din),
		.hs(hs), .vs(vs), .de(de), .r(r), .g(g), .b(b)
	);

	always #5 clk_video = ~clk_video;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	// memory model with din one cycle after rd, driven mid cycle
	always @(negedge clk_video) begin
		if (rd_last)
			din <= mem_word;
		rd_last  <= rd;
		mem_word <= mem[addr[7:0]];
	end

	always @(posedge clk_video)
		rst_edge <= reset;

	// cycle model of timing, fetch and decode checked at the falling edge
	always @(negedge clk_video) begin : model
		logic   fetch, disp, fbit, frame;
		int     nv, i, j;
		color_t own, col;
		if (rst_edge) begin
			mh = 0;
			mv = 0;
			fcnt = 0;
			maddr = '0;
			mnext = 16'h0;
			mgrp = 16'h0;
			shadow = 8'h00;
			fst = 1'b0;
			fflag = 1'b0;
			fcol = BLACK;
			e1 = RESET_OUT;
			e2 = RESET_OUT;
		end else begin
			check_value("hs", e2[20], hs);
			check_value("vs", e2[19], vs);
			check_value("de", e2[18], de);
			check_value("r", e2[17:12], r);
			check_value("g", e2[11:6], g);
			check_value("b", e2[5:0], b);
		end
		nv = (mv == VT - 1) ? 0 : mv + 1;
		// word k at 8k-2 and word 0 at the end of the line before
		fetch = ((mh == HT - 2) && (nv < V_VIS)) ||
			((mh % 8 == 6) && (mh < H_VIS - 2) && (mv < V_VIS));
		frame = (mh == 0) && (mv == 0);
		if (!rst_edge) begin
			check_value("rd", fetch, rd);
			if (fetch)
				check_value("addr", maddr, addr);
		end
		if (fetch)
			mnext = mem[maddr[7:0]];
		if (frame) begin
			shadow = m_stat;
			maddr = shadow[MC_MEMBASE] ? BASE_HIGH : BASE_LOW; // base of the new copy
			if (fcnt == 1) begin
				fcnt = 0;
				fst = !fst; // every second frame
			end else begin
				fcnt++;
			end
		end else if (fetch) begin
			maddr = maddr + 1'b1;
		end
		if (mh % 8 == 0)
			mgrp = mnext;
		if (mh == 0)
			fflag = 1'b0;
		disp = (mh < H_VIS) && (mv < V_VIS);
		i = mh % 8;
		j = i / 2;
		own = {mgrp[7-2*j], mgrp[15-2*j], mgrp[6-2*j]};
		fbit = mgrp[14-2*j];
		if (shadow[MC_MODE])
			col = (fflag && fst && !fbit) ? fcol : own;
		else
			col = {mgrp[7-i], mgrp[15-i], mgrp[7-i] & mgrp[15-i]}; // both bits make white
		if (!disp || shadow[MC_BLANK])
			col = BLACK;
		e2 = e1;
		e1 = {!((mh >= 36) && (mh < 42)), (mv >= 5) && (mv < 7), disp,
			{6{col[2]}}, {6{col[1]}}, {6{col[0]}}};
		if (shadow[MC_MODE] && disp && (i % 2 == 1) && fbit) begin
			fflag = !fflag;
			fcol = own;
		end
		if (mh == HT - 1) begin
			mh = 0;
			mv = nv;
		end else begin
			mh++;
		end
	end

	task automatic axi_write(input logic [3:0] a, input logic [7:0] d, input logic [1:0] resp);
		int hold;
		hold = next_rand() % 4; // bready low span
		@(negedge clk_video);
		awaddr = a;
		wdata = {next_rand() & 32'hffffff00} | d;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		#1;
		while (!awready) begin
			@(negedge clk_video);
			#1;
		end
		check_value("wready", 1, wready);
		if (a == REG_MC_STAT)
			m_stat = d; // taken at the coming rising edge
		@(negedge clk_video);
		awvalid = 1'b0;
		wvalid = 1'b0;
		#1 check_value("bvalid", 1, bvalid);
		repeat (hold) begin
			awvalid = 1'b1; // must stall behind the pending response
			wvalid = 1'b1;
			#1 check_value("awready", 0, awready);
			check_value("wready", 0, wready);
			@(negedge clk_video);
			check_value("bvalid", 1, bvalid);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		check_value("bresp", resp, bresp);
		@(negedge clk_video);
		bready = 1'b0;
		check_value("bvalid", 0, bvalid);
	endtask

	task automatic axi_read(input logic [3:0] a, input logic [31:0] exp, input logic [1:0] resp);
		@(negedge clk_video);
		araddr = a;
		arvalid = 1'b1;
		rready = 1'b0;
		#1;
		while (!arready) begin
			@(negedge clk_video);
			#1;
		end
		@(negedge clk_video);
		arvalid = 1'b0;
		rready = 1'b1;
		check_value("rvalid", 1, rvalid);
		check_value("rdata", exp, rdata);
		check_value("rresp", resp, rresp);
		@(negedge clk_video);
		rready = 1'b0;
		check_value("rvalid", 0, rvalid);
	endtask

	task automatic wait_frames(input int n);
		repeat (n * FRAME) @(negedge clk_video);
	endtask

	initial begin : watchdog
		#(TEST_FRAMES * FRAME * 10 + 5000);
		$display("watchdog timeout, test sequence did not finish");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		logic [31:0] v;
		reset = 1'b1;
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b0;
		din = 16'h0;
		for (int k = 0; k < 256; k++) begin
			v = next_rand();
			mem[k] = v[31:16];
		end
		repeat (8) @(negedge clk_video);
		reset = 1'b0;

		axi_read(REG_MC_STAT, 32'h0, AXI_OKAY);
		repeat (4) begin
			v = next_rand();
			axi_write(REG_MC_STAT, v[7:0], AXI_OKAY);
			axi_read(REG_MC_STAT, {24'h0, m_stat}, AXI_OKAY);
		end
		// bad address leaves MC_STAT alone
		axi_write(4'h4, 8'h5a, AXI_SLVERR);
		axi_read(REG_MC_STAT, {24'h0, m_stat}, AXI_OKAY);
		axi_read(4'h4, 32'h0, AXI_SLVERR);

		axi_write(REG_MC_STAT, 8'h00, AXI_OKAY); // 2bpp with low base
		wait_frames(3);
		axi_write(REG_MC_STAT, 8'h88, AXI_OKAY); // 4bpp with high base
		wait_frames(6);
		repeat (FRAME / 2) @(negedge clk_video);
		axi_write(REG_MC_STAT, 8'h80, AXI_OKAY); // mid frame mode change
		wait_frames(2);
		axi_write(REG_MC_STAT, 8'h8a, AXI_OKAY); // blank
		wait_frames(3);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- src.f
hdl/ql_video_pkg.sv
hdl/mc_stat_regs.sv
hdl/video_timing.sv
hdl/screen_fetch.sv
hdl/pixel_decoder.sv
hdl/zx8301_video.sv
test/tb_zx8301_video.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_zx8301_video
FILELIST  = src.f
PASS_MSG  = ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf obj_dir
